// ==== project.f ====
+incdir+logic
logic/mips_pkg.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_shifter.sv
logic/mips_retire.sv
logic/mips_core.sv
tests/mips_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the core and testbench with Verilator, then runs the simulation
# exit status is nonzero if the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module mips_core_tb -o mips_core_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/mips_core_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

// ==== tests/mips_core_tb.sv ====
// directed testbench for mips_core
// a register model in the bench predicts every write-back record from the MIPS rules
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core_tb;
   import mips_pkg::*;

   logic                  clk;
   logic                  rst_b;
   logic                  in_valid;
   logic                  in_ready;
   logic [`MIPS_XLEN-1:0] instr;
   logic                  out_valid;
   logic                  out_ready;
   wb_t                   wb;
   logic                  halted;
   logic [`MIPS_XLEN-1:0] model_regs [`MIPS_REG_COUNT];  // architectural view
   integer                seed;

   mips_core mips_core_i (.clk(clk), .rst_b(rst_b), .in_valid(in_valid), .in_ready(in_ready),
      .instr(instr), .out_valid(out_valid), .out_ready(out_ready), .wb(wb), .halted(halted));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
      input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
      input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // expected record from the MIPS rules and the model registers
   function automatic wb_t predict(input logic [31:0] ins);
      wb_t         r;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] se;
      logic [31:0] ze;
      logic [4:0]  sh;
      a  = model_regs[ins[25:21]];
      b  = model_regs[ins[20:16]];
      sh = ins[10:6];
      se = {{16{ins[15]}}, ins[15:0]};
      ze = {16'h0000, ins[15:0]};
      r        = '0;
      r.reg_we = 1'b1;
      r.dest   = ins[20:16];  // rt unless R-type
      case (ins[31:26])
         OP_SPECIAL: begin
            r.dest = ins[15:11];
            case (ins[5:0])
               FN_SLL:         r.data = b << sh;
               FN_SRL:         r.data = b >> sh;
               FN_SRA:         r.data = $signed(b) >>> sh;
               FN_SLLV:        r.data = b << a[4:0];  // low 5 bits only
               FN_SRLV:        r.data = b >> a[4:0];
               FN_SRAV:        r.data = $signed(b) >>> a[4:0];
               FN_ADD, FN_ADDU: r.data = a + b;        // no overflow trap
               FN_SUB, FN_SUBU: r.data = a - b;
               FN_AND:         r.data = a & b;
               FN_OR:          r.data = a | b;
               FN_XOR:         r.data = a ^ b;
               FN_NOR:         r.data = ~(a | b);
               FN_SLT:         r.data = {31'd0, $signed(a) < $signed(b)};
               FN_SLTU:        r.data = {31'd0, a < b};
               FN_SYSCALL: begin
                  r.syscall = 1'b1;
                  r.reg_we  = 1'b0;
               end
               default: begin
                  r.reserved = 1'b1;
                  r.reg_we   = 1'b0;
               end
            endcase
         end
         OP_ADDI, OP_ADDIU: r.data = a + se;
         OP_SLTI:           r.data = {31'd0, $signed(a) < $signed(se)};
         OP_SLTIU:          r.data = {31'd0, a < se};  // sext imm with unsigned compare
         OP_ANDI:           r.data = a & ze;
         OP_ORI:            r.data = a | ze;
         OP_XORI:           r.data = a ^ ze;
         OP_LUI:            r.data = {ins[15:0], 16'h0000};
         default: begin
            r.reserved = 1'b1;
            r.reg_we   = 1'b0;
         end
      endcase
      return r;
   endfunction

   task automatic apply(input wb_t w);
      if (w.reg_we && (w.dest != 5'd0)) model_regs[w.dest] = w.data;  // r0 stays 0
   endtask

   // holds in_valid until the core takes the word
   task automatic send_instr(input logic [31:0] ins);
      int n;
      in_valid = 1'b1;
      instr    = ins;
      n        = 0;
      @(negedge clk);
      while (!in_ready) begin
         n++;
         if (n > 1000) begin
            $display("timeout at %0t ns: in_ready never went high", $time);
            abort_run();
         end
         @(negedge clk);
      end
      @(posedge clk);  // accepting edge
      #1 in_valid = 1'b0;
   endtask

   task automatic get_wb(output wb_t got);
      int n;
      out_ready = 1'b1;
      n         = 0;
      @(negedge clk);
      while (!out_valid) begin
         n++;
         if (n > 1000) begin
            $display("timeout at %0t ns: no write-back record arrived", $time);
            abort_run();
         end
         @(negedge clk);
      end
      got = wb;        // mid cycle sample
      @(posedge clk);  // consumed here
      #1 out_ready = 1'b0;
   endtask

   task automatic compare_wb(input wb_t got, input wb_t exp);
      check(32'(got.dest), 32'(exp.dest), "dest");
      check(32'(got.reg_we), 32'(exp.reg_we), "reg_we");
      check(32'(got.reserved), 32'(exp.reserved), "reserved flag");
      check(32'(got.syscall), 32'(exp.syscall), "syscall flag");
      if (exp.reg_we) check(got.data, exp.data, "data");
   endtask

   task automatic exec(input logic [31:0] ins);
      wb_t exp;
      wb_t got;
      exp = predict(ins);
      send_instr(ins);
      get_wb(got);
      compare_wb(got, exp);
      apply(exp);
   endtask

   task automatic load(input logic [4:0] r, input logic [31:0] v);
      exec(itype(OP_LUI, 5'd0, r, v[31:16]));
      exec(itype(OP_ORI, r, r, v[15:0]));
   endtask

   task automatic arith_ops();
      logic [5:0]  fns [10];
      logic [31:0] rnd;
      fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
      rnd = $random(seed);
      load(5'd1, rnd);
      rnd = $random(seed);
      load(5'd2, rnd);
      load(5'd3, 32'h8000_0000);  // most negative
      load(5'd4, 32'h0000_0001);
      for (int i = 0; i < 10; i++) begin
         exec(rtype(fns[i], 5'd1, 5'd2, 5'd5, 5'd0));
         exec(rtype(fns[i], 5'd3, 5'd4, 5'd6, 5'd0));  // signed vs unsigned edge
         exec(rtype(fns[i], 5'd4, 5'd3, 5'd7, 5'd0));
      end
   endtask

   task automatic imm_forms();
      load(5'd10, 32'hffff_ffff);
      exec(itype(OP_ADDI, 5'd1, 5'd5, 16'hfff0));   // negative imm
      exec(itype(OP_ADDIU, 5'd3, 5'd6, 16'h8000));  // wraps past 0x80000000
      exec(itype(OP_SLTI, 5'd1, 5'd7, 16'hffff));
      exec(itype(OP_SLTI, 5'd4, 5'd7, 16'hffff));   // 1 < -1 is false
      exec(itype(OP_SLTIU, 5'd4, 5'd8, 16'hffff));  // 1 < 0xffffffff
      exec(itype(OP_SLTIU, 5'd3, 5'd8, 16'hffff));  // 0x80000000 < 0xffffffff
      exec(itype(OP_ANDI, 5'd10, 5'd9, 16'h8001));  // zero extended
      exec(itype(OP_ORI, 5'd0, 5'd11, 16'h8000));
      exec(itype(OP_XORI, 5'd10, 5'd12, 16'h8000));
   endtask

   task automatic shifts();
      logic [31:0] rnd;
      rnd = $random(seed);
      load(5'd13, rnd | 32'h8000_0000);  // negative for SRA
      load(5'd16, 32'h0000_0025);        // 37 acts as 5
      for (int i = 0; i < 3; i++) begin
         rnd = $random(seed);
         exec(rtype(FN_SLL, 5'd0, 5'd13, 5'd14, rnd[4:0]));
         exec(rtype(FN_SRL, 5'd0, 5'd13, 5'd14, rnd[9:5]));
         exec(rtype(FN_SRA, 5'd0, 5'd13, 5'd14, rnd[14:10]));
         load(5'd15, rnd);
         exec(rtype(FN_SLLV, 5'd15, 5'd13, 5'd17, 5'd0));
         exec(rtype(FN_SRLV, 5'd15, 5'd13, 5'd17, 5'd0));
         exec(rtype(FN_SRAV, 5'd15, 5'd13, 5'd17, 5'd0));
      end
      exec(rtype(FN_SLLV, 5'd16, 5'd13, 5'd18, 5'd0));
      exec(rtype(FN_SRLV, 5'd16, 5'd13, 5'd18, 5'd0));
      exec(rtype(FN_SRAV, 5'd16, 5'd13, 5'd18, 5'd0));
   endtask

   task automatic r0_and_forwarding();
      logic [31:0] i1;
      logic [31:0] i2;
      wb_t         e1;
      wb_t         e2;
      wb_t         got;
      exec(itype(OP_ADDIU, 5'd1, 5'd0, 16'h1234));    // write to r0 dropped
      exec(rtype(FN_OR, 5'd0, 5'd0, 5'd19, 5'd0));    // still zero
      i1 = itype(OP_ADDIU, 5'd0, 5'd20, 16'h0123);
      i2 = rtype(FN_ADDU, 5'd20, 5'd20, 5'd21, 5'd0);  // uses r20 right away
      e1 = predict(i1);
      apply(e1);
      e2 = predict(i2);
      apply(e2);
      out_ready = 1'b1;  // slot drains as the second word goes in
      send_instr(i1);
      check(32'(out_valid), 32'd1, "out_valid one cycle after accept");
      compare_wb(wb, e1);
      send_instr(i2);
      get_wb(got);
      compare_wb(got, e2);
      exec(rtype(FN_OR, 5'd21, 5'd0, 5'd22, 5'd0));
   endtask

   task automatic backpressure();
      logic [31:0] i1;
      logic [31:0] i2;
      wb_t         e1;
      wb_t         e2;
      wb_t         got;
      i1 = itype(OP_ADDIU, 5'd0, 5'd23, 16'h0055);
      i2 = rtype(FN_SUBU, 5'd23, 5'd1, 5'd24, 5'd0);
      e1 = predict(i1);
      apply(e1);
      e2 = predict(i2);
      apply(e2);
      out_ready = 1'b0;
      send_instr(i1);
      in_valid = 1'b1;   // second word waits while slot is full
      instr    = i2;
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         check(32'(in_ready), 32'd0, "in_ready under back-pressure");
      end
      @(posedge clk);
      #1;
      get_wb(got);       // i2 taken on the draining edge
      in_valid = 1'b0;
      compare_wb(got, e1);
      get_wb(got);
      compare_wb(got, e2);
   endtask

   task automatic reserved_and_halt();
      exec(itype(6'h3f, 5'd1, 5'd5, 16'h0001));           // unknown opcode
      exec(rtype(6'h3f, 5'd1, 5'd2, 5'd5, 5'd0));         // unknown funct
      exec(rtype(FN_OR, 5'd5, 5'd0, 5'd25, 5'd0));        // r5 unchanged
      exec(rtype(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      in_valid = 1'b1;
      instr    = itype(OP_ORI, 5'd0, 5'd26, 16'h00aa);
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         check(32'(halted), 32'd1, "halted after SYSCALL");
         check(32'(in_ready), 32'd0, "in_ready while halted");
      end
      @(posedge clk);
      #1 in_valid = 1'b0;
   endtask

   initial begin
      seed      = 32'h3de3d0ba;
      rst_b     = 1'b0;
      in_valid  = 1'b0;
      instr     = '0;
      out_ready = 1'b0;
      for (int i = 0; i < `MIPS_REG_COUNT; i++) model_regs[i] = '0;
      repeat (16) @(posedge clk);
      #1 rst_b = 1'b1;
      @(negedge clk);
      check(32'(out_valid), 32'd0, "out_valid after reset");
      check(32'(halted), 32'd0, "halted after reset");
      check(32'(in_ready), 32'd1, "in_ready after reset");
      @(posedge clk);
      #1;
      exec(rtype(FN_OR, 5'd7, 5'd9, 5'd27, 5'd0));  // cleared registers
      arith_ops();
      imm_forms();
      shifts();
      r0_and_forwarding();
      backpressure();
      reserved_and_halt();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== logic/mips_core.sv ====
// integer MIPS core, one instruction per accepted transfer
// no PC, no memory, no branches; instructions come in on a valid/ready stream
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic [`MIPS_XLEN-1:0] instr,
   output logic                  out_valid,
   input  logic                  out_ready,
   output mips_pkg::wb_t         wb,
   output logic                  halted
);
   import mips_pkg::*;

   ctrl_t                       ctrl;
   logic [`MIPS_XLEN-1:0]       rs_data;
   logic [`MIPS_XLEN-1:0]       rt_data;
   logic [`MIPS_XLEN-1:0]       alu_result;
   logic [`MIPS_XLEN-1:0]       shift_result;
   logic                        rf_we;
   logic [`MIPS_REG_ADDR_W-1:0] rf_waddr;
   logic [`MIPS_XLEN-1:0]       rf_wdata;

   mips_decode decode_i (.instr(instr), .ctrl(ctrl));

   // read addresses straight from the instruction word
   mips_regfile regfile_i (
      .clk(clk), .rst_b(rst_b),
      .raddr_a(instr[`MIPS_RS_MSB:`MIPS_RS_LSB]), .raddr_b(instr[`MIPS_RT_MSB:`MIPS_RT_LSB]),
      .rdata_a(rs_data), .rdata_b(rt_data),
      .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata));

   mips_alu alu_i (.rs_data(rs_data), .rt_data(rt_data), .ctrl(ctrl), .result(alu_result));

   mips_shifter shifter_i (.rs_data(rs_data), .rt_data(rt_data), .ctrl(ctrl),
      .result(shift_result));

   mips_retire retire_i (
      .clk(clk), .rst_b(rst_b), .in_valid(in_valid), .in_ready(in_ready), .ctrl(ctrl),
      .alu_result(alu_result), .shift_result(shift_result),
      .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
      .out_valid(out_valid), .out_ready(out_ready), .wb(wb), .halted(halted));

endmodule

// ==== logic/mips_retire.sv ====
// result mux, regfile write, one-deep output register and halt flag
// register write happens on the accepting edge, record shows up one cycle later
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_retire (
   input  logic                        clk,
   input  logic                        rst_b,
   input  logic                        in_valid,
   output logic                        in_ready,
   input  mips_pkg::ctrl_t             ctrl,
   input  logic [`MIPS_XLEN-1:0]       alu_result,
   input  logic [`MIPS_XLEN-1:0]       shift_result,
   output logic                        rf_we,
   output logic [`MIPS_REG_ADDR_W-1:0] rf_waddr,
   output logic [`MIPS_XLEN-1:0]       rf_wdata,
   output logic                        out_valid,
   input  logic                        out_ready,
   output mips_pkg::wb_t               wb,
   output logic                        halted
);
   import mips_pkg::*;

   logic                  accept;
   logic [`MIPS_XLEN-1:0] lui_value;
   logic [`MIPS_XLEN-1:0] result;

   // imm arrives zero extended, move it to the upper half
   assign lui_value = {ctrl.imm[`MIPS_IMM_W-1:0], {(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}};

   always_comb begin
      case (ctrl.result_src)
         RES_SHIFT: result = shift_result;
         RES_LUI:   result = lui_value;
         default:   result = alu_result;
      endcase
   end

   // room if slot empty or being drained this cycle
   assign in_ready = !halted && (!out_valid || out_ready);
   assign accept   = in_valid && in_ready;

   assign rf_we    = accept && ctrl.reg_we;   // regfile drops r0 itself
   assign rf_waddr = ctrl.dest;
   assign rf_wdata = result;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         out_valid <= 1'b0;
         halted    <= 1'b0;
      end else begin
         if (accept) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;   // consumed, nothing new
         end
         if (accept && ctrl.is_syscall) begin
            halted <= 1'b1;      // sticky until reset
         end
      end
   end

   // payload only, qualified by out_valid
   always_ff @(posedge clk) begin
      if (accept) begin
         wb.dest     <= ctrl.dest;
         wb.data     <= result;
         wb.reg_we   <= ctrl.reg_we;
         wb.reserved <= ctrl.is_reserved;
         wb.syscall  <= ctrl.is_syscall;
      end
   end

endmodule

// ==== logic/mips_shifter.sv ====
// shifts rt by shamt or by rs[4:0], combinational
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_shifter (
   input  logic [`MIPS_XLEN-1:0] rs_data,
   input  logic [`MIPS_XLEN-1:0] rt_data,
   input  mips_pkg::ctrl_t       ctrl,
   output logic [`MIPS_XLEN-1:0] result
);
   import mips_pkg::*;

   logic                     variable;
   logic [`MIPS_SHAMT_W-1:0] amount;

   assign variable = (ctrl.shift_op == SH_SLLV) || (ctrl.shift_op == SH_SRLV) ||
                     (ctrl.shift_op == SH_SRAV);
   // only low 5 bits of rs count for the V forms
   assign amount = variable ? rs_data[`MIPS_SHAMT_W-1:0] : ctrl.shamt;

   always_comb begin
      case (ctrl.shift_op)
         SH_SLL, SH_SLLV: result = rt_data << amount;
         SH_SRL, SH_SRLV: result = rt_data >> amount;              // zero fill
         SH_SRA, SH_SRAV: result = $signed(rt_data) >>> amount;    // sign fill
         default:         result = rt_data;
      endcase
   end

endmodule

// ==== logic/mips_alu.sv ====
// add/sub/logic/compare, combinational
// add and sub simply wrap, there is no overflow output
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_alu (
   input  logic [`MIPS_XLEN-1:0] rs_data,
   input  logic [`MIPS_XLEN-1:0] rt_data,
   input  mips_pkg::ctrl_t       ctrl,
   output logic [`MIPS_XLEN-1:0] result
);
   import mips_pkg::*;

   logic [`MIPS_XLEN-1:0] op_b;
   logic                  lt_signed;
   logic                  lt_unsigned;

   assign op_b = ctrl.use_imm ? ctrl.imm : rt_data;  // imm forms replace rt

   // both compares always built, alu_op picks one
   assign lt_signed   = $signed(rs_data) < $signed(op_b);
   assign lt_unsigned = rs_data < op_b;

   always_comb begin
      case (ctrl.alu_op)
         ALU_ADD:  result = rs_data + op_b;
         ALU_SUB:  result = rs_data - op_b;
         ALU_AND:  result = rs_data & op_b;
         ALU_OR:   result = rs_data | op_b;
         ALU_XOR:  result = rs_data ^ op_b;
         ALU_NOR:  result = ~(rs_data | op_b);
         ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
         ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
         default:  result = '0;
      endcase
   end

endmodule

// ==== logic/mips_regfile.sv ====
// 32 x 32 register file, combinational reads, write on rising clk
// r0 is hardwired to zero and swallows writes
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_regfile (
   input  logic                        clk,
   input  logic                        rst_b,
   input  logic [`MIPS_REG_ADDR_W-1:0] raddr_a,
   input  logic [`MIPS_REG_ADDR_W-1:0] raddr_b,
   output logic [`MIPS_XLEN-1:0]       rdata_a,
   output logic [`MIPS_XLEN-1:0]       rdata_b,
   input  logic                        we,
   input  logic [`MIPS_REG_ADDR_W-1:0] waddr,
   input  logic [`MIPS_XLEN-1:0]       wdata
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

   // architectural state, cleared so every register reads zero after reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;   // r0 never written
      end
   end

   // read ports, r0 forced
   assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
   assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// ==== logic/mips_decode.sv ====
// pure combinational decode, no state
// ADD/ADDI are decoded like ADDU/ADDIU since overflow traps are not kept
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_decode (
   input  logic [`MIPS_XLEN-1:0] instr,
   output mips_pkg::ctrl_t       ctrl
);
   import mips_pkg::*;

   opcode_e                     opcode;
   funct_e                      funct;
   logic [`MIPS_IMM_W-1:0]      imm16;
   logic [`MIPS_REG_ADDR_W-1:0] rt;
   logic [`MIPS_REG_ADDR_W-1:0] rd;

   assign opcode = opcode_e'(instr[`MIPS_OP_MSB:`MIPS_OP_LSB]);
   assign funct  = funct_e'(instr[`MIPS_FUNCT_MSB:`MIPS_FUNCT_LSB]);
   assign imm16  = instr[`MIPS_IMM_W-1:0];
   assign rt     = instr[`MIPS_RT_MSB:`MIPS_RT_LSB];
   assign rd     = instr[`MIPS_RD_MSB:`MIPS_RD_LSB];

   always_comb begin
      ctrl            = '0;
      ctrl.alu_op     = ALU_ADD;
      ctrl.shift_op   = SH_SLL;
      ctrl.result_src = RES_ALU;
      ctrl.shamt      = instr[`MIPS_SHAMT_MSB:`MIPS_SHAMT_LSB];
      ctrl.imm        = {{(`MIPS_XLEN-`MIPS_IMM_W){imm16[`MIPS_IMM_W-1]}}, imm16};  // sext
      ctrl.dest       = rt;                 // immediate forms write rt
      ctrl.reg_we     = 1'b1;
      case (opcode)
         OP_SPECIAL: begin
            ctrl.dest = rd;
            case (funct)
               FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;   // no trap, wraps
               FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:          ctrl.alu_op = ALU_AND;
               FN_OR:           ctrl.alu_op = ALU_OR;
               FN_XOR:          ctrl.alu_op = ALU_XOR;
               FN_NOR:          ctrl.alu_op = ALU_NOR;
               FN_SLT:          ctrl.alu_op = ALU_SLT;
               FN_SLTU:         ctrl.alu_op = ALU_SLTU;
               FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
                  ctrl.result_src = RES_SHIFT;
                  ctrl.shift_op   = shift_op_e'(funct[2:0]);  // same encoding
               end
               FN_SYSCALL: begin
                  ctrl.reg_we     = 1'b0;   // halt only, no write
                  ctrl.is_syscall = 1'b1;
               end
               default: begin
                  ctrl.reg_we      = 1'b0;
                  ctrl.is_reserved = 1'b1;
               end
            endcase
         end
         OP_ADDI, OP_ADDIU: ctrl.use_imm = 1'b1;
         OP_SLTI: begin
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = ALU_SLT;
         end
         OP_SLTIU: begin
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = ALU_SLTU;  // imm still sign extended, per ISA
         end
         OP_ANDI, OP_ORI, OP_XORI: begin
            ctrl.use_imm = 1'b1;
            ctrl.imm     = {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm16};  // logic ops zext
            ctrl.alu_op  = (opcode == OP_ANDI) ? ALU_AND :
                           (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
         end
         OP_LUI: begin
            ctrl.imm        = {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, imm16};
            ctrl.result_src = RES_LUI;  // retire builds the upper half
         end
         default: begin
            ctrl.reg_we      = 1'b0;
            ctrl.is_reserved = 1'b1;
         end
      endcase
   end

endmodule

// ==== logic/mips_pkg.sv ====
// shared types for the core; widths come from mips_params.svh
// only the integer subset is encoded, everything else decodes as reserved
`include "mips_params.svh"

package mips_pkg;

   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,  // R-type, look at funct
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f
   } opcode_e;

   typedef enum logic [5:0] {
      FN_SLL = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
      FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
      FN_SYSCALL = 6'h0c,
      FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
      FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27,
      FN_SLT = 6'h2a, FN_SLTU = 6'h2b
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
   } alu_op_e;

   // encoding matches funct[2:0] of the shift group
   typedef enum logic [2:0] {
      SH_SLL = 3'd0, SH_SRL = 3'd2, SH_SRA = 3'd3,
      SH_SLLV = 3'd4, SH_SRLV = 3'd6, SH_SRAV = 3'd7
   } shift_op_e;

   typedef enum logic [1:0] {RES_ALU, RES_SHIFT, RES_LUI} result_src_e;

   typedef struct packed {
      alu_op_e                     alu_op;
      shift_op_e                   shift_op;
      result_src_e                 result_src;
      logic                        use_imm;     // op b is imm, not rt
      logic [`MIPS_XLEN-1:0]       imm;         // already extended
      logic [`MIPS_SHAMT_W-1:0]    shamt;
      logic [`MIPS_REG_ADDR_W-1:0] dest;        // rd or rt
      logic                        reg_we;
      logic                        is_syscall;
      logic                        is_reserved;
   } ctrl_t;

   typedef struct packed {
      logic [`MIPS_REG_ADDR_W-1:0] dest;
      logic [`MIPS_XLEN-1:0]       data;
      logic                        reg_we;
      logic                        reserved;    // unknown instruction
      logic                        syscall;
   } wb_t;

endpackage

// ==== logic/mips_params.svh ====
// fixed MIPS32 widths and instruction field positions
// these are set by the ISA and are not meant to be changed
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_XLEN        32  // data word
`define MIPS_REG_COUNT   32  // architectural registers
`define MIPS_REG_ADDR_W  5
`define MIPS_SHAMT_W     5

// instruction word fields, msb/lsb pairs
`define MIPS_OP_MSB      31
`define MIPS_OP_LSB      26
`define MIPS_RS_MSB      25
`define MIPS_RS_LSB      21
`define MIPS_RT_MSB      20
`define MIPS_RT_LSB      16
`define MIPS_RD_MSB      15
`define MIPS_RD_LSB      11
`define MIPS_SHAMT_MSB   10
`define MIPS_SHAMT_LSB   6
`define MIPS_FUNCT_MSB   5
`define MIPS_FUNCT_LSB   0
`define MIPS_IMM_W       16  // imm field sits at the bottom of the word

`endif
